// File: vlog.f
axi_wr_pkg.sv
axi_wr_if.sv
skid_buf.sv
axi_burst_addr.sv
axi_wr_sub.sv
wr_sram.sv
axi_wr_sram_top.sv
tb_axi_wr_assert.sv
tb_axi_wr.sv

// File: Bender.yml
package:
  name: axi_wr_sram

sources:
  - axi_wr_pkg.sv
  - axi_wr_if.sv
  - skid_buf.sv
  - axi_burst_addr.sv
  - axi_wr_sub.sv
  - wr_sram.sv
  - axi_wr_sram_top.sv
  - target: test
    files:
      - tb_axi_wr_assert.sv
      - tb_axi_wr.sv

// File: tb_axi_wr.sv
/* Testbench for the AXI write path, stops at the first mismatch.
   Bursts stay inside 4 KB and WRAP starts are size aligned */
`timescale 1ns/1ns

module tb_axi_wr;
    import axi_wr_pkg::*;

    localparam int AW    = 32;
    localparam int DW    = 32;
    localparam int IW    = 4;
    localparam int UW    = 8;
    localparam int DEPTH = 256;
    localparam int BC    = DW / 8;
    localparam int TMO   = 2000;

    logic                     clk;
    logic                     rst_n;
    logic                     i_awvalid;
    logic                     o_awready;
    logic [AW-1:0]            i_awaddr;
    logic [1:0]               i_awburst;
    logic [2:0]               i_awsize;
    logic [AXI_LEN_W-1:0]     i_awlen;
    logic [IW-1:0]            i_awid;
    logic [UW-1:0]            i_awuser;
    logic                     i_wvalid;
    logic                     o_wready;
    logic [DW-1:0]            i_wdata;
    logic [BC-1:0]            i_wstrb;
    logic                     i_wlast;
    logic                     o_bvalid;
    logic                     i_bready;
    axi_resp_e                o_bresp;
    logic [IW-1:0]            o_bid;
    logic                     i_rd_en;
    logic [$clog2(DEPTH)-1:0] i_rd_addr;
    logic [DW-1:0]            o_rd_data;

    // Byte-wide reference memory and in-order expected responses
    logic [7:0]    ref_mem [DEPTH*BC];
    logic [IW-1:0] exp_id_q [$];
    axi_resp_e     exp_resp_q [$];
    bit            rd_noise;

    axi_wr_sram_top #(
        .AW    (AW),
        .DW    (DW),
        .IW    (IW),
        .UW    (UW),
        .DEPTH (DEPTH)
    ) u_axi_wr_sram_top (.*);

    bind axi_wr_sub tb_axi_wr_assert #(.AW(AW), .DW(DW), .IW(IW)) u_sub_assert (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_awvalid    (s_axi.awvalid),
        .i_awready    (s_axi.awready),
        .i_awaddr     (s_axi.awaddr),
        .i_awlen      (s_axi.awlen),
        .i_awid       (s_axi.awid),
        .i_wvalid     (s_axi.wvalid),
        .i_wready     (s_axi.wready),
        .i_wdata      (s_axi.wdata),
        .i_wstrb      (s_axi.wstrb),
        .i_wlast      (s_axi.wlast),
        .i_bvalid     (s_axi.bvalid),
        .i_bready     (s_axi.bready),
        .i_bresp      (s_axi.bresp),
        .i_bid        (s_axi.bid),
        .i_dv         (comp.dv),
        .i_hld        (comp.hld),
        .i_addr       (comp.addr),
        .i_cdata      (comp.wdata),
        .i_cstrb      (comp.wstrb),
        .i_last       (comp.last),
        .i_final_beat (txn_final_beat)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "Run stopped");
    endtask

    // ------------------------------
    // Background traffic
    // ------------------------------
    // Random B back-pressure, roughly one stall in four
    always @(posedge clk) begin
        #1;
        i_bready = rst_n && ($urandom_range(3, 0) != 0);
    end

    // Random reads that hold write beats
    always @(posedge clk) begin
        #1;
        if (rd_noise) begin
            i_rd_en   = ($urandom_range(2, 0) == 0);
            i_rd_addr = $urandom;
        end
    end

    // B checker, transfer happens at the next rising edge
    always @(negedge clk) begin
        if (rst_n && o_bvalid && i_bready) begin
            assert (exp_id_q.size() != 0)
                else fail_stop("B response arrived with no burst outstanding");
            assert (o_bid === exp_id_q[0])
                else fail_stop($sformatf("** Error o_bid: got %h expected %h",
                                         o_bid, exp_id_q[0]));
            assert (o_bresp === exp_resp_q[0])
                else fail_stop($sformatf("** Error o_bresp: got %h expected %h",
                                         o_bresp, exp_resp_q[0]));
            void'(exp_id_q.pop_front());
            void'(exp_resp_q.pop_front());
        end
    end

    always @(posedge clk) begin
        if (u_axi_wr_sram_top.u_axi_wr_sub.u_sub_assert.fail_seen) begin
            fail_stop("A concurrent protocol assertion failed");
        end
    end

    // ------------------------------
    // Manager tasks
    // ------------------------------
    task automatic send_aw(input int addr, input axi_burst_e burst, input int size,
                           input int len, input int id);
        int t;
        i_awvalid = 1'b1;
        i_awaddr  = AW'(addr);
        i_awburst = burst;
        i_awsize  = 3'(size);
        i_awlen   = AXI_LEN_W'(len);
        i_awid    = IW'(id);
        i_awuser  = $urandom;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > TMO) fail_stop("Timeout waiting for o_awready");
        end while (!o_awready);
        @(posedge clk);
        #1;
        i_awvalid = 1'b0;
    endtask

    task automatic send_w(input logic [DW-1:0] data, input logic [BC-1:0] strb,
                          input bit last);
        int t;
        i_wvalid = 1'b1;
        i_wdata  = data;
        i_wstrb  = strb;
        i_wlast  = last;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > TMO) fail_stop("Timeout waiting for o_wready");
        end while (!o_wready);
        @(posedge clk);
        #1;
        i_wvalid = 1'b0;
    endtask

    // One burst, model updated beat by beat from the AXI address rules
    task automatic do_burst(input int addr, input axi_burst_e burst, input int size,
                            input int len, input int id, input bit full);
        int            nbytes;
        int            span;
        int            a;
        int            lane_lo;
        int            lane_hi;
        bit            err;
        logic [DW-1:0] data;
        logic [BC-1:0] strb;
        nbytes = 1 << size;
        span   = nbytes * (len + 1);
        err    = 1'b0;
        send_aw(addr, burst, size, len, id);
        for (int n = 0; n <= len; n++) begin
            case (burst)
                AXI_BURST_FIXED: a = addr;
                AXI_BURST_WRAP:  a = (addr / span) * span + (addr + n * nbytes) % span;
                default:         a = (n == 0) ? addr : (addr / nbytes + n) * nbytes;
            endcase
            // Valid lanes, first INCR beat may start mid-lane
            lane_lo = a % BC;
            lane_hi = ((a / nbytes) * nbytes) % BC + nbytes - 1;
            data    = $urandom;
            strb    = '0;
            for (int b = lane_lo; b <= lane_hi; b++) begin
                strb[b] = full || ($urandom_range(1, 0) != 0);
            end
            if (a / BC >= DEPTH) begin
                err = 1'b1;
            end else begin
                for (int b = 0; b < BC; b++) begin
                    if (strb[b]) ref_mem[(a / BC) * BC + b] = data[8*b +: 8];
                end
            end
            send_w(data, strb, n == len);
        end
        exp_id_q.push_back(IW'(id));
        exp_resp_q.push_back(err ? AXI_RESP_SLVERR : AXI_RESP_OKAY);
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_id_q.size() != 0) begin
            @(posedge clk);
            #1;
            t++;
            if (t > TMO) fail_stop("Timeout waiting for outstanding B responses");
        end
    endtask

    // Read every word back and compare with the model
    task automatic check_mem();
        logic [DW-1:0] exp;
        for (int w = 0; w < DEPTH; w++) begin
            i_rd_en   = 1'b1;
            i_rd_addr = w;
            @(posedge clk);
            #1;
            i_rd_en = 1'b0;
            @(negedge clk);
            for (int b = 0; b < BC; b++) begin
                exp[8*b +: 8] = ref_mem[w * BC + b];
            end
            assert (o_rd_data === exp)
                else fail_stop($sformatf("** Error o_rd_data word %h: got %h expected %h",
                                         w, o_rd_data, exp));
            @(posedge clk);
            #1;
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int kind;
        int size;
        int addr;
        void'($urandom(32'ha7e0));
        rst_n     = 1'b0;
        rd_noise  = 1'b0;
        i_awvalid = 1'b0;
        i_awaddr  = '0;
        i_awburst = '0;
        i_awsize  = '0;
        i_awlen   = '0;
        i_awid    = '0;
        i_awuser  = '0;
        i_wvalid  = 1'b0;
        i_wdata   = '0;
        i_wstrb   = '0;
        i_wlast   = 1'b0;
        i_bready  = 1'b0;
        i_rd_en   = 1'b0;
        i_rd_addr = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert ({o_awready, o_wready, o_bvalid} === 3'b000)
            else fail_stop($sformatf("** Error o_awready/o_wready/o_bvalid after reset: %h",
                                     {o_awready, o_wready, o_bvalid}));

        // Fill the whole memory with one long INCR burst
        do_burst(0, AXI_BURST_INCR, 2, DEPTH - 1, 0, 1'b1);

        // Single beats, full then partial strobes
        for (int i = 0; i < 8; i++) begin
            do_burst($urandom_range(DEPTH - 1, 0) * BC, AXI_BURST_INCR, 2, 0, i, i < 4);
        end
        wait_drain();
        check_mem();

        // Narrow INCR bursts, lengths 1 to 16
        for (int len = 0; len < 16; len++) begin
            do_burst($urandom_range(900, 0), AXI_BURST_INCR, len % 3, len, len, 1'b0);
        end
        wait_drain();
        check_mem();

        // WRAP of 2, 4, 8 and 16 beats, then FIXED
        for (int k = 0; k < 4; k++) begin
            size = 2 - (k % 2);
            // Start one beat into the block so the last beat wraps to its base
            addr = ($urandom_range(900, 0) & ~(((2 << k) << size) - 1)) + (1 << size);
            do_burst(addr, AXI_BURST_WRAP, size, (2 << k) - 1, k, 1'b1);
        end
        do_burst(512, AXI_BURST_FIXED, 2, 3, 5, 1'b1);
        do_burst(701, AXI_BURST_FIXED, 0, 5, 6, 1'b0);
        wait_drain();
        check_mem();

        // Range error, in-range beats of the same burst still land
        do_burst(DEPTH * BC - 8, AXI_BURST_INCR, 2, 3, 9, 1'b1);
        do_burst(4096, AXI_BURST_INCR, 2, 0, 10, 1'b1);
        do_burst(64, AXI_BURST_INCR, 2, 1, 11, 1'b1);
        wait_drain();
        check_mem();

        // Back-to-back mixed bursts under read contention
        rd_noise = 1'b1;
        for (int i = 0; i < 12; i++) begin
            kind = $urandom_range(2, 0);
            size = $urandom_range(2, 0);
            addr = $urandom_range(900, 0) & ~((1 << size) - 1);
            case (kind)
                0: do_burst(addr, AXI_BURST_FIXED, size, $urandom_range(7, 0), i, 1'b0);
                1: do_burst(addr, AXI_BURST_INCR, size, $urandom_range(15, 0), i, 1'b0);
                default: do_burst(addr, AXI_BURST_WRAP, size,
                                  (2 << $urandom_range(3, 0)) - 1, i, 1'b0);
            endcase
        end
        wait_drain();
        rd_noise = 1'b0;
        i_rd_en  = 1'b0;
        check_mem();

        if (u_axi_wr_sram_top.u_axi_wr_sub.u_sub_assert.fail_seen) begin
            fail_stop("A concurrent protocol assertion failed");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// File: tb_axi_wr_assert.sv
/* Protocol checks bound into axi_wr_sub, idle while rst_n is low.
   Covers the AXI handshakes and the component beat hold */
`timescale 1ns/1ns

module tb_axi_wr_assert #(
    parameter int AW = axi_wr_pkg::AXI_AW,
    parameter int DW = 32,
    parameter int IW = axi_wr_pkg::AXI_IW
) (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            i_awvalid,
    input logic                            i_awready,
    input logic [AW-1:0]                   i_awaddr,
    input logic [axi_wr_pkg::AXI_LEN_W-1:0] i_awlen,
    input logic [IW-1:0]                   i_awid,
    input logic                            i_wvalid,
    input logic                            i_wready,
    input logic [DW-1:0]                   i_wdata,
    input logic [DW/8-1:0]                 i_wstrb,
    input logic                            i_wlast,
    input logic                            i_bvalid,
    input logic                            i_bready,
    input logic [1:0]                      i_bresp,
    input logic [IW-1:0]                   i_bid,
    input logic                            i_dv,
    input logic                            i_hld,
    input logic [AW-1:0]                   i_addr,
    input logic [DW-1:0]                   i_cdata,
    input logic [DW/8-1:0]                 i_cstrb,
    input logic                            i_last,
    input logic                            i_final_beat
);

    // Sticky flag, polled by the testbench top
    bit fail_seen = 1'b0;

    // ------------------------------
    // AXI channels
    // ------------------------------
    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        i_awvalid && !i_awready |=> i_awvalid && $stable({i_awaddr, i_awlen, i_awid}))
        else begin
            $error("AW request dropped or changed while stalled");
            fail_seen = 1'b1;
        end

    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        i_wvalid && !i_wready |=> i_wvalid && $stable({i_wdata, i_wstrb, i_wlast}))
        else begin
            $error("W beat dropped or changed while stalled");
            fail_seen = 1'b1;
        end

    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        i_bvalid && !i_bready |=> i_bvalid && $stable({i_bresp, i_bid}))
        else begin
            $error("B response dropped or changed while stalled");
            fail_seen = 1'b1;
        end

    // A response needs a consumed last beat the cycle before
    a_b_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_bvalid) |-> $past(i_final_beat))
        else begin
            $error("B response raised without a consumed last beat");
            fail_seen = 1'b1;
        end

    // ------------------------------
    // Component beat and known values
    // ------------------------------
    a_beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
        i_dv && i_hld |=> i_dv && $stable({i_addr, i_cdata, i_cstrb, i_last}))
        else begin
            $error("Component beat changed while held");
            fail_seen = 1'b1;
        end

    a_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({i_awready, i_wready, i_bvalid, i_dv}))
        else begin
            $error("Handshake output unknown outside reset");
            fail_seen = 1'b1;
        end

    a_b_known: assert property (@(posedge clk) disable iff (!rst_n)
        i_bvalid |-> !$isunknown({i_bresp, i_bid}))
        else begin
            $error("B payload unknown while valid");
            fail_seen = 1'b1;
        end

endmodule

// File: axi_wr_sram_top.sv
/* AXI4 write path into on-chip memory, plain AXI ports plus a read port.
   Write-only AXI: no AR or R channel, no lock, cache or prot */
`timescale 1ns/1ns

module axi_wr_sram_top #(
    parameter int AW    = axi_wr_pkg::AXI_AW,
    parameter int DW    = 32,
    parameter int IW    = axi_wr_pkg::AXI_IW,
    parameter int UW    = axi_wr_pkg::AXI_UW,
    parameter int DEPTH = 256
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // AW channel
    input  logic                            i_awvalid,
    output logic                            o_awready,
    input  logic [AW-1:0]                   i_awaddr,
    input  logic [1:0]                      i_awburst,
    input  logic [2:0]                      i_awsize,
    input  logic [axi_wr_pkg::AXI_LEN_W-1:0] i_awlen,
    input  logic [IW-1:0]                   i_awid,
    input  logic [UW-1:0]                   i_awuser,
    // W channel
    input  logic                            i_wvalid,
    output logic                            o_wready,
    input  logic [DW-1:0]                   i_wdata,
    input  logic [DW/8-1:0]                 i_wstrb,
    input  logic                            i_wlast,
    // B channel
    output logic                            o_bvalid,
    input  logic                            i_bready,
    output axi_wr_pkg::axi_resp_e           o_bresp,
    output logic [IW-1:0]                   o_bid,
    // Memory read port
    input  logic                            i_rd_en,
    input  logic [$clog2(DEPTH)-1:0]        i_rd_addr,
    output logic [DW-1:0]                   o_rd_data
);

    axi_wr_if #(.AW(AW), .DW(DW), .IW(IW), .UW(UW)) u_axi_if ();
    comp_wr_if #(.AW(AW), .DW(DW)) u_comp_if ();

    // Manager side of the AXI bundle
    assign u_axi_if.awvalid = i_awvalid;
    assign u_axi_if.awaddr  = i_awaddr;
    assign u_axi_if.awburst = i_awburst;
    assign u_axi_if.awsize  = i_awsize;
    assign u_axi_if.awlen   = i_awlen;
    assign u_axi_if.awid    = i_awid;
    assign u_axi_if.awuser  = i_awuser;
    assign u_axi_if.wvalid  = i_wvalid;
    assign u_axi_if.wdata   = i_wdata;
    assign u_axi_if.wstrb   = i_wstrb;
    assign u_axi_if.wlast   = i_wlast;
    assign u_axi_if.bready  = i_bready;

    assign o_awready = u_axi_if.awready;
    assign o_wready  = u_axi_if.wready;
    assign o_bvalid  = u_axi_if.bvalid;
    assign o_bresp   = u_axi_if.bresp;
    assign o_bid     = u_axi_if.bid;

    axi_wr_sub #(
        .AW (AW),
        .DW (DW),
        .IW (IW),
        .UW (UW)
    ) u_axi_wr_sub (
        .clk   (clk),
        .rst_n (rst_n),
        .s_axi (u_axi_if.w_sub),
        .comp  (u_comp_if.sub)
    );

    wr_sram #(
        .AW    (AW),
        .DW    (DW),
        .DEPTH (DEPTH)
    ) u_wr_sram (
        .clk       (clk),
        .rst_n     (rst_n),
        .comp      (u_comp_if.mem),
        .i_rd_en   (i_rd_en),
        .i_rd_addr (i_rd_addr),
        .o_rd_data (o_rd_data)
    );

endmodule

// File: wr_sram.sv
/* Single-port word memory with byte strobes and a read port that wins over writes.
   Beats at or above DEPTH flag err and are dropped; read data lags i_rd_en by one cycle */
`timescale 1ns/1ns

module wr_sram #(
    parameter int AW    = axi_wr_pkg::AXI_AW,
    parameter int DW    = 32,
    parameter int DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     rst_n,
    comp_wr_if.mem                   comp,
    input  logic                     i_rd_en,
    input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
    output logic [DW-1:0]            o_rd_data
);

    localparam int BC    = DW / 8;
    localparam int BW    = $clog2(BC);
    localparam int IDX_W = $clog2(DEPTH);

    logic [DW-1:0]    mem [DEPTH];
    logic [AW-BW-1:0] word_idx;
    logic             wr_en;

    // Word index from the aligned byte address
    assign word_idx = comp.addr[AW-1:BW];
    assign comp.err = (word_idx >= (AW-BW)'(DEPTH));

    // Read cycle stalls any write beat
    assign comp.hld = i_rd_en;
    assign wr_en    = comp.dv && !comp.hld && !comp.err;

    // Bytewise write under strobe
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < BC; b++) begin
                if (comp.wstrb[b]) begin
                    mem[word_idx[IDX_W-1:0]][8*b +: 8] <= comp.wdata[8*b +: 8];
                end
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rd_data <= '0;
        end else if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

// File: axi_wr_sub.sv
/* AXI4 write subordinate, one active burst, in-order B responses.
   W beats are taken only while a burst is active; bus and component widths match */
`timescale 1ns/1ns

module axi_wr_sub #(
    parameter int AW = axi_wr_pkg::AXI_AW,
    parameter int DW = 32,
    parameter int IW = axi_wr_pkg::AXI_IW,
    parameter int UW = axi_wr_pkg::AXI_UW
) (
    input  logic      clk,
    input  logic      rst_n,
    axi_wr_if.w_sub   s_axi,
    comp_wr_if.sub    comp
);
    import axi_wr_pkg::*;

    localparam int BC = DW / 8;
    localparam int BW = $clog2(BC);

    // AW request context
    typedef struct packed {
        logic [AW-1:0]        addr;
        axi_burst_e           burst;
        logic [2:0]           size;
        logic [AXI_LEN_W-1:0] len;
        logic [IW-1:0]        id;
        logic [UW-1:0]        user;
    } req_ctx_t;

    // W beat payload
    typedef struct packed {
        logic [DW-1:0] data;
        logic [BC-1:0] strb;
        logic          last;
    } w_beat_t;

    // B response payload
    typedef struct packed {
        axi_resp_e     resp;
        logic [IW-1:0] id;
    } b_rsp_t;

    req_ctx_t      aw_ctx;
    req_ctx_t      req_ctx;
    logic          req_valid;
    logic          req_ready;
    req_ctx_t      txn_ctx;
    logic [AW-1:0] txn_addr_nxt;
    logic          txn_active;
    logic          txn_err;
    logic          txn_final_beat;
    logic          beat_fire;

    w_beat_t       w_in;
    w_beat_t       w_out;
    logic          w_valid;
    logic          w_ready;
    logic          w_out_valid;

    b_rsp_t        rp_data;
    b_rsp_t        b_out;
    logic          rp_valid;
    logic          rp_ready;

    // ------------------------------
    // Request path
    // ------------------------------
    always_comb begin
        aw_ctx.addr  = s_axi.awaddr;
        aw_ctx.burst = axi_burst_e'(s_axi.awburst);
        aw_ctx.size  = s_axi.awsize;
        aw_ctx.len   = s_axi.awlen;
        aw_ctx.id    = s_axi.awid;
        aw_ctx.user  = s_axi.awuser;
    end

    // Pass-through stage so an accepted AW loads the context next edge
    skid_buf #(
        .payload_t (req_ctx_t),
        .OUT_REG   (1'b0)
    ) u_req_skd (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (s_axi.awvalid),
        .o_ready (s_axi.awready),
        .i_data  (aw_ctx),
        .o_valid (req_valid),
        .i_ready (req_ready),
        .o_data  (req_ctx)
    );

    // Component beat taken this cycle
    assign beat_fire      = comp.dv && !comp.hld;
    assign txn_final_beat = beat_fire && comp.last;

    // Next burst only with a free response slot
    // Overlap with the final beat only when B is empty, so its response fits
    assign req_ready = (!txn_active || (txn_final_beat && !s_axi.bvalid)) && rp_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_active <= 1'b0;
            txn_ctx    <= '0;
            txn_err    <= 1'b0;
        end else if (req_valid && req_ready) begin
            txn_active <= 1'b1;
            txn_ctx    <= req_ctx;
            txn_err    <= 1'b0;
        end else begin
            if (txn_final_beat) begin
                txn_active <= 1'b0;
            end
            // Advance per beat and keep any error sticky
            if (beat_fire) begin
                txn_ctx.addr <= txn_addr_nxt;
                txn_err      <= txn_err || comp.err;
            end
        end
    end

    // Full unaligned address feeds the calculator for narrow sizes
    axi_burst_addr #(
        .AW (AW),
        .DW (DW)
    ) u_burst_addr (
        .i_last_addr (txn_ctx.addr),
        .i_size      (txn_ctx.size),
        .i_burst     (txn_ctx.burst),
        .i_len       (txn_ctx.len),
        .o_next_addr (txn_addr_nxt)
    );

    // ------------------------------
    // Data path
    // ------------------------------
    assign w_in    = '{data: s_axi.wdata, strb: s_axi.wstrb, last: s_axi.wlast};
    assign w_valid = s_axi.wvalid && txn_active;
    assign s_axi.wready = w_ready && txn_active;

    // Registered output puts the first beat one cycle after the W handshake
    skid_buf #(
        .payload_t (w_beat_t),
        .OUT_REG   (1'b1)
    ) u_w_skd (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (w_valid),
        .o_ready (w_ready),
        .i_data  (w_in),
        .o_valid (w_out_valid),
        .i_ready (txn_active && !comp.hld),
        .o_data  (w_out)
    );

    // Beats of a following burst wait here until its context loads
    assign comp.dv    = w_out_valid && txn_active;
    assign comp.addr  = {txn_ctx.addr[AW-1:BW], BW'(0)};
    assign comp.wdata = w_out.data;
    assign comp.wstrb = w_out.strb;
    assign comp.last  = w_out.last;

    // ------------------------------
    // Response path
    // ------------------------------
    assign rp_valid     = txn_final_beat;
    assign rp_data.resp = (txn_err || comp.err) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    assign rp_data.id   = txn_ctx.id;

    skid_buf #(
        .payload_t (b_rsp_t),
        .OUT_REG   (1'b1)
    ) u_b_skd (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (rp_valid),
        .o_ready (rp_ready),
        .i_data  (rp_data),
        .o_valid (s_axi.bvalid),
        .i_ready (s_axi.bready),
        .o_data  (b_out)
    );

    assign s_axi.bresp = b_out.resp;
    assign s_axi.bid   = b_out.id;

endmodule

// File: axi_burst_addr.sv
/* Next-beat byte address for FIXED, INCR and WRAP bursts. WRAP assumes a
   size-aligned start and a length of 2, 4, 8 or 16; reserved acts as FIXED */
`timescale 1ns/1ns

module axi_burst_addr #(
    parameter int AW = axi_wr_pkg::AXI_AW,
    parameter int DW = 32
) (
    input  logic [AW-1:0]                     i_last_addr,
    input  logic [2:0]                        i_size,
    input  axi_wr_pkg::axi_burst_e            i_burst,
    input  logic [axi_wr_pkg::AXI_LEN_W-1:0]  i_len,
    output logic [AW-1:0]                     o_next_addr
);
    import axi_wr_pkg::*;

    localparam int BW = $clog2(DW / 8);

    logic [2:0]    eff_size;
    logic [AW-1:0] beat_bytes;
    logic [AW-1:0] addr_algn;
    logic [AW-1:0] addr_incr;
    logic [AW-1:0] wrap_mask;
    logic [AW-1:0] addr_wrap;

    // Sizes wider than the bus are clamped to the bus width
    assign eff_size   = (i_size > 3'(BW)) ? 3'(BW) : i_size;
    assign beat_bytes = AW'(1) << eff_size;

    // Unaligned start only matters for the first beat
    assign addr_algn  = i_last_addr & ~(beat_bytes - AW'(1));
    assign addr_incr  = addr_algn + beat_bytes;

    // Wrap block is size x (len + 1) bytes
    assign wrap_mask  = ((AW'(i_len) + AW'(1)) << eff_size) - AW'(1);
    assign addr_wrap  = (i_last_addr & ~wrap_mask) | (addr_incr & wrap_mask);

    always_comb begin
        case (i_burst)
            AXI_BURST_INCR: o_next_addr = addr_incr;
            AXI_BURST_WRAP: o_next_addr = addr_wrap;
            // FIXED and reserved repeat the address
            default:        o_next_addr = i_last_addr;
        endcase
    end

endmodule

// File: skid_buf.sv
/* Valid/ready register stage with one skid entry, any packed payload type.
   o_ready is registered and stays low during reset and the first cycle */
`timescale 1ns/1ns

module skid_buf #(
    parameter type payload_t = logic,
    parameter bit  OUT_REG   = 1'b0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_valid,
    output logic     o_ready,
    input  payload_t i_data,
    output logic     o_valid,
    input  logic     i_ready,
    output payload_t o_data
);

    logic     skid_valid;
    logic     skid_valid_nxt;
    logic     skid_load;
    payload_t skid_data;
    logic     in_fire;

    // Upstream transfer
    assign in_fire = i_valid && o_ready;

    // Ready is the registered inverse of the next skid state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            skid_valid <= 1'b0;
            o_ready    <= 1'b0;
        end else begin
            skid_valid <= skid_valid_nxt;
            o_ready    <= !skid_valid_nxt;
        end
    end

    // Skid entry catches one item while downstream stalls
    always_ff @(posedge clk) begin
        if (skid_load) begin
            skid_data <= i_data;
        end
    end

    if (OUT_REG) begin : g_out_reg
        logic     out_valid;
        logic     out_free;
        payload_t out_data;

        // Output register can take a new item this cycle
        assign out_free       = !out_valid || i_ready;
        assign skid_load      = in_fire && !out_free;
        assign skid_valid_nxt = skid_load || (skid_valid && !out_free);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                out_valid <= 1'b0;
            end else if (out_free) begin
                out_valid <= skid_valid || in_fire;
            end
        end

        // Skid entry drains first to keep order
        always_ff @(posedge clk) begin
            if (out_free && skid_valid) begin
                out_data <= skid_data;
            end else if (out_free && in_fire) begin
                out_data <= i_data;
            end
        end

        assign o_valid = out_valid;
        assign o_data  = out_data;
    end else begin : g_out_comb
        // Input passes straight through unless the skid entry is full
        assign skid_load      = in_fire && !i_ready;
        assign skid_valid_nxt = skid_load || (skid_valid && !i_ready);

        assign o_valid = skid_valid || in_fire;
        assign o_data  = skid_valid ? skid_data : i_data;
    end

endmodule

// File: axi_wr_if.sv
/* AXI4 write channels (AW, W, B) and the internal component write bus.
   No lock, cache or prot signals; the component bus has no handshake */
`timescale 1ns/1ns

interface axi_wr_if #(
    parameter int AW = axi_wr_pkg::AXI_AW,
    parameter int DW = 32,
    parameter int IW = axi_wr_pkg::AXI_IW,
    parameter int UW = axi_wr_pkg::AXI_UW
);
    import axi_wr_pkg::*;

    // AW channel
    logic                 awvalid;
    logic                 awready;
    logic [AW-1:0]        awaddr;
    logic [1:0]           awburst;
    logic [2:0]           awsize;
    logic [AXI_LEN_W-1:0] awlen;
    logic [IW-1:0]        awid;
    logic [UW-1:0]        awuser;

    // W channel
    logic                 wvalid;
    logic                 wready;
    logic [DW-1:0]        wdata;
    logic [DW/8-1:0]      wstrb;
    logic                 wlast;

    // B channel
    logic                 bvalid;
    logic                 bready;
    axi_resp_e            bresp;
    logic [IW-1:0]        bid;

    // Subordinate side drives the readies and the response
    modport w_sub (
        input  awvalid, awaddr, awburst, awsize, awlen, awid, awuser,
        output awready,
        input  wvalid, wdata, wstrb, wlast,
        output wready,
        output bvalid, bresp, bid,
        input  bready
    );

    // Manager side drives requests and data
    modport w_mgr (
        output awvalid, awaddr, awburst, awsize, awlen, awid, awuser,
        input  awready,
        output wvalid, wdata, wstrb, wlast,
        input  wready,
        input  bvalid, bresp, bid,
        output bready
    );

endinterface

interface comp_wr_if #(
    parameter int AW = axi_wr_pkg::AXI_AW,
    parameter int DW = 32
);
    // Beat strobe and payload from the subordinate
    logic            dv;
    logic [AW-1:0]   addr;  // Byte address, word aligned
    logic [DW-1:0]   wdata;
    logic [DW/8-1:0] wstrb;
    logic            last;  // Marks the final beat of a burst
    // Stall and per-beat error from the memory
    logic            hld;
    logic            err;

    modport sub (output dv, addr, wdata, wstrb, last, input hld, err);
    modport mem (input dv, addr, wdata, wstrb, last, output hld, err);

endinterface

// File: axi_wr_pkg.sv
/* Shared AXI write-path types and default widths. No exclusive access:
   EXOKAY and DECERR exist in the response code but are never returned */
package axi_wr_pkg;

    // ------------------------------
    // Default widths
    // ------------------------------
    // Defaults for the top-level parameters, passed down from there
    localparam int AXI_AW    = 32;
    localparam int AXI_IW    = 4;
    localparam int AXI_UW    = 8;

    // AxLEN field width, fixed by the AXI4 spec
    localparam int AXI_LEN_W = 8;

    // ------------------------------
    // Channel encodings
    // ------------------------------
    // Burst kind as carried on AWBURST
    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10,
        AXI_BURST_RSVD  = 2'b11
    } axi_burst_e;

    // Response code as carried on BRESP
    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_EXOKAY = 2'b01,
        AXI_RESP_SLVERR = 2'b10,
        AXI_RESP_DECERR = 2'b11
    } axi_resp_e;

endpackage
